//--- bench/rvfiToRvviTb.sv
////////////////////////////////////////////////////////////
// RVFI to RVVI converter testbench
// Table-driven retirement rows and net change steps,
// checked against values worked out from the trace rules
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rvfiToRvviTb;

    localparam int XLen          = rvviTracePkg::XLen;
    localparam int NumRegs       = rvviTracePkg::NumRegs;
    localparam int NumCsr        = rvviTracePkg::NumCsr;
    localparam int NumPorts      = rvviTracePkg::NumWritePorts;
    localparam int NumRows       = 6;
    localparam int NumSteps      = 5;
    localparam int NetWaitCycles = 8;
    // Implemented lines: MSI, MTI, MEI and local 16 to 31
    localparam logic [XLen-1:0] WatchedLines = 32'hFFFF_0888;
    // Destination registers per row, row 0 lowest
    localparam logic [NumRows-1:0][4:0] Addr0Col = {5'd4, 5'd31, 5'd0, 5'd7, 5'd0, 5'd1};
    localparam logic [NumRows-1:0][4:0] Addr1Col = {5'd4, 5'd3, 5'd0, 5'd7, 5'd5, 5'd2};

    // DUT inputs
    logic                                 rvvi;
    logic                                 arstN_i;
    logic                                 rvfiValid_i;
    logic                                 rvfiTrap_i;
    logic                                 rvfiIntr_i;
    logic [63:0]                          rvfiOrder_i;
    logic [XLen-1:0]                      rvfiInsn_i;
    logic [1:0]                           rvfiMode_i;
    logic [XLen-1:0]                      rvfiPc_i;
    logic [NumPorts-1:0][4:0]             rvfiRdAddr_i;
    logic [NumPorts-1:0][XLen-1:0]        rvfiRdWdata_i;
    logic [NumCsr-1:0][XLen-1:0]          csrRdata_i;
    logic [NumCsr-1:0][XLen-1:0]          csrWdata_i;
    logic [NumCsr-1:0][XLen-1:0]          csrWmask_i;
    logic [XLen-1:0]                      irq_i;
    logic                                 debugReq_i;
    // DUT outputs
    logic                                 rvviValid_o;
    logic                                 rvviTrap_o;
    logic                                 rvviIntr_o;
    logic [63:0]                          rvviOrder_o;
    logic [XLen-1:0]                      rvviInsn_o;
    logic [1:0]                           rvviMode_o;
    logic [XLen-1:0]                      rvviPc_o;
    logic [NumRegs-1:0]                   xWb_o;
    logic [NumRegs-1:0][XLen-1:0]         xWdata_o;
    logic [NumCsr-1:0][XLen-1:0]          csrValue_o;
    logic [NumCsr-1:0]                    csrWb_o;
    logic                                 netPush_o;
    logic [XLen-1:0]                      irqValue_o;
    logic                                 haltReq_o;
    logic [XLen:0]                        netChanged_o;

    ////////////////////////////////////////////////////////////
    // Stimulus and expected value table
    ////////////////////////////////////////////////////////////

    logic [63:0]                 tOrder  [NumRows];
    logic [XLen-1:0]             tInsn   [NumRows];
    logic [XLen-1:0]             tPc     [NumRows];
    logic [1:0]                  tMode   [NumRows];
    logic                        tTrap   [NumRows];
    logic                        tIntr   [NumRows];
    logic [XLen-1:0]             tData0  [NumRows];
    logic [XLen-1:0]             tData1  [NumRows];
    logic [NumCsr-1:0][XLen-1:0] tRd     [NumRows];
    logic [NumCsr-1:0][XLen-1:0] tWd     [NumRows];
    logic [NumCsr-1:0][XLen-1:0] tWm     [NumRows];
    logic [NumCsr-1:0][XLen-1:0] tExpCsr [NumRows];
    logic [NumCsr-1:0]           tExpCsrWb [NumRows];
    logic [NumRegs-1:0]          tExpXWb [NumRows];
    // Net steps
    logic [XLen-1:0]             nIrq    [NumSteps];
    logic                        nHalt   [NumSteps];
    logic                        nExpPush [NumSteps];
    logic [XLen:0]               nExpChanged [NumSteps];

    logic [15:0] lfsrState;
    int          checkCount;
    int          errorCount;

    rvfiToRvvi uut (.*);

    initial begin
        rvvi = 1'b0;
        forever #2 rvvi = ~rvvi;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        end
        return v;
    endfunction

    // Port 1 beats port 0 on the same index, x0 never written
    function automatic logic [XLen-1:0] expGprData(input int r, input int g);
        if (g != 0 && Addr1Col[r] == g) return tData1[r];
        if (g != 0 && Addr0Col[r] == g) return tData0[r];
        return '0;
    endfunction

    task automatic buildTable();
        logic [NumCsr-1:0][XLen-1:0] last;
        logic [XLen-1:0]             prevIrq;
        logic                        prevHalt;
        last = '0;
        for (int r = 0; r < NumRows; r++) begin
            tOrder[r] = 64'h0000_0001_0000_0000 + 64'(r);
            tInsn[r]  = randBits(32);
            tPc[r]    = randBits(32);
            tMode[r]  = 2'(randBits(2));
            tTrap[r]  = 1'(randBits(1));
            tIntr[r]  = 1'(randBits(1));
            tData0[r] = randBits(32);
            tData1[r] = randBits(32);
            for (int s = 0; s < NumCsr; s++) begin
                tWd[r][s] = randBits(32);
                // Row 3 repeats the last values, nothing should flag
                tRd[r][s] = (r == 3) ? last[s] : randBits(32);
                tWm[r][s] = (r == 3) ? '0 : randBits(32);
                // Mstatus merges to zero on row 0, equal to reset value
                if (r == 0 && s == 0) begin
                    tRd[r][s] = '0;
                    tWm[r][s] = '0;
                end
                tExpCsr[r][s]   = tRd[r][s] ^ ((tRd[r][s] ^ tWd[r][s]) & tWm[r][s]);
                tExpCsrWb[r][s] = (tExpCsr[r][s] != last[s]);
                last[s]         = tExpCsr[r][s];
            end
            tExpXWb[r] = '0;
            if (Addr0Col[r] != 0) tExpXWb[r][Addr0Col[r]] = 1'b1;
            if (Addr1Col[r] != 0) tExpXWb[r][Addr1Col[r]] = 1'b1;
        end
        // Watched MSI, unwatched bit 0, halt, local lines, bit 0 again
        nIrq[0] = 32'h0000_0008;
        nHalt[0] = 1'b0;
        nIrq[1] = 32'h0000_0009;
        nHalt[1] = 1'b0;
        nIrq[2] = 32'h0000_0009;
        nHalt[2] = 1'b1;
        nIrq[3] = 32'h8001_0009;
        nHalt[3] = 1'b1;
        nIrq[4] = 32'h8001_0008;
        nHalt[4] = 1'b1;
        prevIrq  = '0;
        prevHalt = 1'b0;
        for (int s = 0; s < NumSteps; s++) begin
            nExpChanged[s] = {nHalt[s] ^ prevHalt, (nIrq[s] ^ prevIrq) & WatchedLines};
            nExpPush[s]    = |nExpChanged[s];
            prevIrq        = nIrq[s];
            prevHalt       = nHalt[s];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic checkRetire(input string name, input logic [63:0] got, input logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkCsr(input int slot, input logic [XLen-1:0] got, input logic [XLen-1:0] exp,
                            input logic gotWb, input logic expWb);
        checkCount += 2;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR csrValue_o[%0d] got %h expected %h", slot, got, exp);
        end
        if (gotWb !== expWb) begin
            errorCount++;
            $display("ERROR csrWb_o[%0d] got %h expected %h", slot, gotWb, expWb);
        end
    endtask

    task automatic checkGprMask(input logic [NumRegs-1:0] got, input logic [NumRegs-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR xWb_o got %h expected %h", got, exp);
        end
    endtask

    task automatic checkGprData(input int idx, input logic [XLen-1:0] got,
                                input logic [XLen-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR xWdata_o[%0d] got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic checkNet(input string name, input logic [XLen:0] got, input logic [XLen:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errorCount == errBefore) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errorCount - errBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Row and step runners
    ////////////////////////////////////////////////////////////

    task automatic driveRow(input int r);
        rvfiValid_i   = 1'b1;
        rvfiOrder_i   = tOrder[r];
        rvfiInsn_i    = tInsn[r];
        rvfiPc_i      = tPc[r];
        rvfiMode_i    = tMode[r];
        rvfiTrap_i    = tTrap[r];
        rvfiIntr_i    = tIntr[r];
        rvfiRdAddr_i  = {Addr1Col[r], Addr0Col[r]};
        rvfiRdWdata_i = {tData1[r], tData0[r]};
        csrRdata_i    = tRd[r];
        csrWdata_i    = tWd[r];
        csrWmask_i    = tWm[r];
    endtask

    // Outputs of row r, one clock after its strobe
    task automatic checkRow(input int r);
        int errBefore;
        errBefore = errorCount;
        checkRetire("rvviValid_o", 64'(rvviValid_o), 64'd1);
        checkRetire("rvviOrder_o", rvviOrder_o, tOrder[r]);
        checkRetire("rvviInsn_o", 64'(rvviInsn_o), 64'(tInsn[r]));
        checkRetire("rvviPc_o", 64'(rvviPc_o), 64'(tPc[r]));
        checkRetire("rvviMode_o", 64'(rvviMode_o), 64'(tMode[r]));
        checkRetire("rvviTrap_o", 64'(rvviTrap_o), 64'(tTrap[r]));
        checkRetire("rvviIntr_o", 64'(rvviIntr_o), 64'(tIntr[r]));
        for (int s = 0; s < NumCsr; s++) begin
            checkCsr(s, csrValue_o[s], tExpCsr[r][s], csrWb_o[s], tExpCsrWb[r][s]);
        end
        checkGprMask(xWb_o, tExpXWb[r]);
        for (int g = 0; g < NumRegs; g++) begin
            checkGprData(g, xWdata_o[g], expGprData(r, g));
        end
        reportTest($sformatf("retire row %0d", r), errBefore);
    endtask

    task automatic runNetStep(input int s);
        logic seen;
        int   errBefore;
        seen      = 1'b0;
        errBefore = errorCount;
        @(negedge rvvi);
        irq_i      = nIrq[s];
        debugReq_i = nHalt[s];
        for (int i = 0; i < NetWaitCycles && !seen; i++) begin
            @(negedge rvvi);
            seen = netPush_o;
        end
        checkCount++;
        if (nExpPush[s] && !seen) begin
            errorCount++;
            $display("Timeout: no netPush_o strobe within %0d cycles", NetWaitCycles);
        end else if (!nExpPush[s] && seen) begin
            errorCount++;
            $display("netPush_o strobed although only unwatched lines moved");
        end else if (seen) begin
            checkNet("irqValue_o", {1'b0, irqValue_o}, {1'b0, nIrq[s] & WatchedLines});
            checkNet("haltReq_o", 33'(haltReq_o), 33'(nHalt[s]));
            checkNet("netChanged_o", netChanged_o, nExpChanged[s]);
        end
        reportTest($sformatf("net step %0d", s), errBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int errBefore;
        lfsrState     = 16'd61312;
        checkCount    = 0;
        errorCount    = 0;
        arstN_i       = 1'b0;
        rvfiValid_i   = 1'b0;
        rvfiTrap_i    = 1'b0;
        rvfiIntr_i    = 1'b0;
        rvfiOrder_i   = '0;
        rvfiInsn_i    = '0;
        rvfiMode_i    = '0;
        rvfiPc_i      = '0;
        rvfiRdAddr_i  = '0;
        rvfiRdWdata_i = '0;
        csrRdata_i    = '0;
        csrWdata_i    = '0;
        csrWmask_i    = '0;
        irq_i         = '0;
        debugReq_i    = 1'b0;
        buildTable();
        repeat (4) @(posedge rvvi);
        @(negedge rvvi);
        arstN_i = 1'b1;

        // Reset state
        errBefore = errorCount;
        @(negedge rvvi);
        checkRetire("rvviValid_o", 64'(rvviValid_o), 64'd0);
        checkNet("netPush_o", 33'(netPush_o), 33'd0);
        checkGprMask(xWb_o, '0);
        for (int s = 0; s < NumCsr; s++) checkCsr(s, csrValue_o[s], '0, csrWb_o[s], 1'b0);
        reportTest("reset", errBefore);

        // Back-to-back retirements, row r checked while row r+1 goes in
        for (int r = 0; r <= NumRows; r++) begin
            @(negedge rvvi);
            if (r > 0) checkRow(r - 1);
            if (r < NumRows) driveRow(r);
            else rvfiValid_i = 1'b0;
        end

        // Idle cycle, CSR values held and flags cleared
        errBefore = errorCount;
        @(negedge rvvi);
        checkRetire("rvviValid_o", 64'(rvviValid_o), 64'd0);
        checkGprMask(xWb_o, '0);
        for (int s = 0; s < NumCsr; s++) begin
            checkCsr(s, csrValue_o[s], tExpCsr[NumRows-1][s], csrWb_o[s], 1'b0);
        end
        reportTest("idle", errBefore);

        for (int s = 0; s < NumSteps; s++) runNetStep(s);

        // Property failures from the bound checker count as errors
        errorCount += uut.propsI.failCount;

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/rvfiToRvvi_props.sv
////////////////////////////////////////////////////////////
// Trace converter properties
// Strobe timing and mask rules, bound into the top level
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rvfiToRvviProps #(
    parameter int NumCsr = rvviTracePkg::NumCsr
) (
    input wire                               rvvi,
    input wire                               arstN_i,
    input wire                               rvfiValid_i,
    input wire                               rvviValid_o,
    input wire [NumCsr-1:0]                  csrWb_o,
    input wire [rvviTracePkg::NumRegs-1:0]   xWb_o,
    input wire [rvviTracePkg::XLen-1:0]      irq_i,
    input wire                               debugReq_i,
    input wire                               netPush_o
);

    // Failed property count
    int failCount = 0;

    // Output strobe trails the input strobe by one clock
    validFollows: assert property (@(posedge rvvi) disable iff (!arstN_i)
        rvviValid_o == $past(rvfiValid_i))
        else begin
            failCount++;
            $error("rvviValid_o did not follow rvfiValid_i by one cycle");
        end

    // x0 is hardwired
    noX0Write: assert property (@(posedge rvvi) disable iff (!arstN_i) !xWb_o[0])
        else begin
            failCount++;
            $error("xWb_o bit 0 set");
        end

    flagsNeedValid: assert property (@(posedge rvvi) disable iff (!arstN_i)
        !rvviValid_o |-> (csrWb_o == '0) && (xWb_o == '0))
        else begin
            failCount++;
            $error("write-back flags set without rvviValid_o");
        end

    // One push cycle for each watched net move, sampled two clocks back
    pushOnChange: assert property (@(posedge rvvi) disable iff (!arstN_i)
        netPush_o == ((|(($past(irq_i, 2) ^ $past(irq_i, 3)) & rvviTracePkg::IrqWatchMask))
                      || ($past(debugReq_i, 2) != $past(debugReq_i, 3))))
        else begin
            failCount++;
            $error("netPush_o does not match a watched net change");
        end

endmodule

bind rvfiToRvvi rvfiToRvviProps #(.NumCsr(NumCsr)) propsI (
    .rvvi        (rvvi),
    .arstN_i     (arstN_i),
    .rvfiValid_i (rvfiValid_i),
    .rvviValid_o (rvviValid_o),
    .csrWb_o     (csrWb_o),
    .xWb_o       (xWb_o),
    .irq_i       (irq_i),
    .debugReq_i  (debugReq_i),
    .netPush_o   (netPush_o)
);

`default_nettype wire

//--- flist.f
hdl/rvviTracePkg.sv
hdl/csrMerge.sv
hdl/retireWriteback.sv
hdl/netChangeDetect.sv
hdl/rvfiToRvvi.sv
bench/rvfiToRvvi_props.sv
bench/rvfiToRvviTb.sv

//--- hdl/csrMerge.sv
////////////////////////////////////////////////////////////
// CSR merge
// Builds each traced CSR from written and unwritten bits
// and flags the slots whose value moved on retirement
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module csrMerge #(
    parameter int NumCsr = 6
) (
    input  wire                                            rvvi,
    input  wire                                            arstN_i,
    input  wire                                            rvfiValid_i,
    input  wire  [NumCsr-1:0][rvviTracePkg::XLen-1:0]      csrRdata_i,
    input  wire  [NumCsr-1:0][rvviTracePkg::XLen-1:0]      csrWdata_i,
    input  wire  [NumCsr-1:0][rvviTracePkg::XLen-1:0]      csrWmask_i,
    output logic [NumCsr-1:0][rvviTracePkg::XLen-1:0]      csrValue_o,
    output logic [NumCsr-1:0]                              csrWb_o
);

    localparam int XLen = rvviTracePkg::XLen;

    // Merged value per slot
    logic [NumCsr-1:0][XLen-1:0] mergedValue;
    // Slot differs from last reported value
    logic [NumCsr-1:0]           slotChanged;

    ////////////////////////////////////////////////////////////
    // Merge
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < NumCsr; s++) begin
            // Written bits from wdata, the rest from rdata
            mergedValue[s] = (csrWdata_i[s] & csrWmask_i[s])
                           | (csrRdata_i[s] & ~csrWmask_i[s]);
            // Compare against the stored copy
            slotChanged[s] = (mergedValue[s] != csrValue_o[s]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stored values and write-back flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            csrValue_o <= '0;
            csrWb_o    <= '0;
        end else if (rvfiValid_i) begin
            // Capture on retirement only
            csrValue_o <= mergedValue;
            csrWb_o    <= slotChanged;
        end else begin
            // Flags live for the output strobe cycle
            csrWb_o <= '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/netChangeDetect.sv
////////////////////////////////////////////////////////////
// Net change detector
// Samples the watched interrupt lines and the halt request
// and strobes once per change
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module netChangeDetect (
    input  wire                              rvvi,
    input  wire                              arstN_i,
    input  wire  [rvviTracePkg::XLen-1:0]    irq_i,
    input  wire                              debugReq_i,
    output logic                             netPush_o,
    output logic [rvviTracePkg::XLen-1:0]    irqValue_o,
    output logic                             haltReq_o,
    output logic [rvviTracePkg::XLen:0]      netChanged_o
);

    localparam int XLen = rvviTracePkg::XLen;

    // Current and previous samples
    logic [XLen-1:0] irqSample;
    logic [XLen-1:0] irqPrev;
    logic            haltSample;
    logic            haltPrev;

    // Halt request sits above the irq lines
    logic [XLen:0]   netDiff;

    assign netDiff = {haltSample ^ haltPrev, irqSample ^ irqPrev};

    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            irqSample    <= '0;
            irqPrev      <= '0;
            haltSample   <= 1'b0;
            haltPrev     <= 1'b0;
            netPush_o    <= 1'b0;
            irqValue_o   <= '0;
            haltReq_o    <= 1'b0;
            netChanged_o <= '0;
        end else begin
            // Unimplemented lines masked off at the sample
            irqSample    <= irq_i & rvviTracePkg::IrqWatchMask;
            haltSample   <= debugReq_i;
            irqPrev      <= irqSample;
            haltPrev     <= haltSample;
            // One strobe per sample that moved
            netPush_o    <= |netDiff;
            irqValue_o   <= irqSample;
            haltReq_o    <= haltSample;
            netChanged_o <= netDiff;
        end
    end

endmodule

`default_nettype wire

//--- hdl/retireWriteback.sv
////////////////////////////////////////////////////////////
// Retirement and GPR write-back
// Registers the retired instruction fields and turns the
// destination register ports into a mask and data array
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module retireWriteback #(
    parameter int NumWritePorts = 2
) (
    input  wire                                                 rvvi,
    input  wire                                                 arstN_i,
    input  wire                                                 rvfiValid_i,
    input  wire                                                 rvfiTrap_i,
    input  wire                                                 rvfiIntr_i,
    input  wire  [rvviTracePkg::OrderBits-1:0]                  rvfiOrder_i,
    input  wire  [rvviTracePkg::XLen-1:0]                       rvfiInsn_i,
    input  wire  [rvviTracePkg::ModeBits-1:0]                   rvfiMode_i,
    input  wire  [rvviTracePkg::XLen-1:0]                       rvfiPc_i,
    input  wire  [NumWritePorts-1:0][rvviTracePkg::RegAddrBits-1:0] rvfiRdAddr_i,
    input  wire  [NumWritePorts-1:0][rvviTracePkg::XLen-1:0]    rvfiRdWdata_i,
    output logic                                                rvviValid_o,
    output logic                                                rvviTrap_o,
    output logic                                                rvviIntr_o,
    output logic [rvviTracePkg::OrderBits-1:0]                  rvviOrder_o,
    output logic [rvviTracePkg::XLen-1:0]                       rvviInsn_o,
    output logic [rvviTracePkg::ModeBits-1:0]                   rvviMode_o,
    output logic [rvviTracePkg::XLen-1:0]                       rvviPc_o,
    output logic [rvviTracePkg::NumRegs-1:0]                    xWb_o,
    output logic [rvviTracePkg::NumRegs-1:0][rvviTracePkg::XLen-1:0] xWdata_o
);

    localparam int XLen    = rvviTracePkg::XLen;
    localparam int NumRegs = rvviTracePkg::NumRegs;

    // Decoded write-back of the current retirement
    logic [NumRegs-1:0]           wbNext;
    logic [NumRegs-1:0][XLen-1:0] wdataNext;

    ////////////////////////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        wbNext    = '0;
        wdataNext = '0;
        // Ascending walk, so the higher port overrides
        for (int p = 0; p < NumWritePorts; p++) begin
            // x0 is hardwired, never reported
            if (rvfiRdAddr_i[p] != '0) begin
                wbNext[rvfiRdAddr_i[p]]    = 1'b1;
                wdataNext[rvfiRdAddr_i[p]] = rvfiRdWdata_i[p];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    // Strobe and mask
    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            rvviValid_o <= 1'b0;
            xWb_o       <= '0;
        end else begin
            rvviValid_o <= rvfiValid_i;
            xWb_o       <= rvfiValid_i ? wbNext : '0;
        end
    end

    // Payload, loaded on retirement and held otherwise
    always_ff @(posedge rvvi) begin
        if (rvfiValid_i) begin
            rvviTrap_o  <= rvfiTrap_i;
            rvviIntr_o  <= rvfiIntr_i;
            rvviOrder_o <= rvfiOrder_i;
            rvviInsn_o  <= rvfiInsn_i;
            rvviMode_o  <= rvfiMode_i;
            rvviPc_o    <= rvfiPc_i;
            // Unwritten slots come out as zero
            xWdata_o    <= wdataNext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rvfiToRvvi.sv
////////////////////////////////////////////////////////////
// RVFI to RVVI trace converter
// Retirement, CSR and net change blocks on the rvvi clock
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rvfiToRvvi #(
    parameter int NumCsr        = rvviTracePkg::NumCsr,
    parameter int NumWritePorts = rvviTracePkg::NumWritePorts
) (
    input  wire                                                 rvvi,
    input  wire                                                 arstN_i,
    // RVFI retirement record
    input  wire                                                 rvfiValid_i,
    input  wire                                                 rvfiTrap_i,
    input  wire                                                 rvfiIntr_i,
    input  wire  [rvviTracePkg::OrderBits-1:0]                  rvfiOrder_i,
    input  wire  [rvviTracePkg::XLen-1:0]                       rvfiInsn_i,
    input  wire  [rvviTracePkg::ModeBits-1:0]                   rvfiMode_i,
    input  wire  [rvviTracePkg::XLen-1:0]                       rvfiPc_i,
    input  wire  [NumWritePorts-1:0][rvviTracePkg::RegAddrBits-1:0] rvfiRdAddr_i,
    input  wire  [NumWritePorts-1:0][rvviTracePkg::XLen-1:0]    rvfiRdWdata_i,
    input  wire  [NumCsr-1:0][rvviTracePkg::XLen-1:0]           csrRdata_i,
    input  wire  [NumCsr-1:0][rvviTracePkg::XLen-1:0]           csrWdata_i,
    input  wire  [NumCsr-1:0][rvviTracePkg::XLen-1:0]           csrWmask_i,
    // Core nets
    input  wire  [rvviTracePkg::XLen-1:0]                       irq_i,
    input  wire                                                 debugReq_i,
    // RVVI trace
    output logic                                                rvviValid_o,
    output logic                                                rvviTrap_o,
    output logic                                                rvviIntr_o,
    output logic [rvviTracePkg::OrderBits-1:0]                  rvviOrder_o,
    output logic [rvviTracePkg::XLen-1:0]                       rvviInsn_o,
    output logic [rvviTracePkg::ModeBits-1:0]                   rvviMode_o,
    output logic [rvviTracePkg::XLen-1:0]                       rvviPc_o,
    output logic [rvviTracePkg::NumRegs-1:0]                    xWb_o,
    output logic [rvviTracePkg::NumRegs-1:0][rvviTracePkg::XLen-1:0] xWdata_o,
    output logic [NumCsr-1:0][rvviTracePkg::XLen-1:0]           csrValue_o,
    output logic [NumCsr-1:0]                                   csrWb_o,
    output logic                                                netPush_o,
    output logic [rvviTracePkg::XLen-1:0]                       irqValue_o,
    output logic                                                haltReq_o,
    output logic [rvviTracePkg::XLen:0]                         netChanged_o
);

    ////////////////////////////////////////////////////////////
    // Retirement side, both fed by the same valid
    ////////////////////////////////////////////////////////////

    retireWriteback #(
        .NumWritePorts(NumWritePorts)
    ) retireWritebackI (
        .rvvi          (rvvi),
        .arstN_i       (arstN_i),
        .rvfiValid_i   (rvfiValid_i),
        .rvfiTrap_i    (rvfiTrap_i),
        .rvfiIntr_i    (rvfiIntr_i),
        .rvfiOrder_i   (rvfiOrder_i),
        .rvfiInsn_i    (rvfiInsn_i),
        .rvfiMode_i    (rvfiMode_i),
        .rvfiPc_i      (rvfiPc_i),
        .rvfiRdAddr_i  (rvfiRdAddr_i),
        .rvfiRdWdata_i (rvfiRdWdata_i),
        .rvviValid_o   (rvviValid_o),
        .rvviTrap_o    (rvviTrap_o),
        .rvviIntr_o    (rvviIntr_o),
        .rvviOrder_o   (rvviOrder_o),
        .rvviInsn_o    (rvviInsn_o),
        .rvviMode_o    (rvviMode_o),
        .rvviPc_o      (rvviPc_o),
        .xWb_o         (xWb_o),
        .xWdata_o      (xWdata_o)
    );

    csrMerge #(
        .NumCsr(NumCsr)
    ) csrMergeI (
        .rvvi        (rvvi),
        .arstN_i     (arstN_i),
        .rvfiValid_i (rvfiValid_i),
        .csrRdata_i  (csrRdata_i),
        .csrWdata_i  (csrWdata_i),
        .csrWmask_i  (csrWmask_i),
        .csrValue_o  (csrValue_o),
        .csrWb_o     (csrWb_o)
    );

    // Nets are sampled every clock, independent of retirement
    netChangeDetect netChangeDetectI (
        .rvvi         (rvvi),
        .arstN_i      (arstN_i),
        .irq_i        (irq_i),
        .debugReq_i   (debugReq_i),
        .netPush_o    (netPush_o),
        .irqValue_o   (irqValue_o),
        .haltReq_o    (haltReq_o),
        .netChanged_o (netChanged_o)
    );

endmodule

`default_nettype wire

//--- hdl/rvviTracePkg.sv
////////////////////////////////////////////////////////////
// RVVI trace definitions
// Word widths, register counts, CSR slot numbers and the
// watched interrupt lines of the RVFI to RVVI converter
////////////////////////////////////////////////////////////

`default_nettype none

package rvviTracePkg;

    ////////////////////////////////////////////////////////////
    // Core geometry
    ////////////////////////////////////////////////////////////

    // Data and address word
    localparam int XLen        = 32;

    // Integer register file
    localparam int NumRegs     = 32;
    localparam int RegAddrBits = 5;

    // RVFI destination register ports
    localparam int NumWritePorts = 2;

    // Retirement counter and privilege mode
    localparam int OrderBits = 64;
    localparam int ModeBits  = 2;

    ////////////////////////////////////////////////////////////
    // Traced machine CSRs
    ////////////////////////////////////////////////////////////

    localparam int NumCsr = 6;

    // Slot positions in the packed CSR buses, slot 0 lowest
    localparam int CsrSlotMstatus  = 0;
    localparam int CsrSlotMie      = 1;
    localparam int CsrSlotMtvec    = 2;
    localparam int CsrSlotMscratch = 3;
    localparam int CsrSlotMepc     = 4;
    localparam int CsrSlotMcause   = 5;

    ////////////////////////////////////////////////////////////
    // Interrupt lines
    ////////////////////////////////////////////////////////////

    // MSI, MTI, MEI and the sixteen local lines 16 to 31
    localparam logic [XLen-1:0] IrqWatchMask = 32'hFFFF_0888;

endpackage

`default_nettype wire
